//--- sim.f
common/cache_pkg.sv
verilog/cache_ram.sv
cache/cache_lookup.sv
cache/mem_request_fifo.sv
cache/mem_sequencer.sv
verilog/snowball_cache_top.sv
bench/cache_assertions.sv
bench/cache_tb.sv

//--- bench/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

  import cache_pkg::*;

  logic              CPU_CLK;
  logic              RST;
  logic [ADDR_W-1:0] cache_addr;
  logic [DATA_W-1:0] cache_wdata;
  logic              cache_we;
  logic              cache_enable;
  logic              tlb_we;
  logic              cache_inhibit;
  logic              vmem_act;
  logic [DATA_W-1:0] cache_rdata;
  logic              cache_busy;
  logic              cache_done;
  logic              mmu_fault;
  logic              dma_mcu_access;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_we;
  logic              mem_do_act;
  logic [DATA_W-1:0] mem_dataintomem;
  logic              mem_ack;
  logic [DATA_W-1:0] mem_datafrommem;

  // ----------------------------------------
  // reference model state
  // ----------------------------------------
  logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];    // program-order memory
  logic [DATA_W-1:0] bus_mem [logic [ADDR_W-1:0]];    // what the bus really wrote
  mem_op_t           exp_ops [$];                     // bus ops still owed, in order
  bit                c_valid [ENTRIES];
  logic [CTAG_W-1:0] c_tag [ENTRIES];
  bit                t_valid [ENTRIES];
  logic [VTAG_W-1:0] t_ptag [ENTRIES];
  logic [VTAG_W-1:0] t_vtag [ENTRIES];

  logic [31:0] main_seed;
  logic [31:0] bus_seed;
  int          ack_delay;
  bit          stress;
  bit          hung;
  string       test_name;
  int          data_errors;
  int          bus_errors;
  int          timing_errors;
  int          hang_errors;
  mem_op_t     bus_op;

  snowball_cache_top snowball_cache_top_i (.*);

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // untouched words read back as a pattern of their address
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
  endfunction

  function automatic logic [31:0] ref_word(input logic [31:0] a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
  endfunction

  function automatic logic [31:0] bus_word(input logic [31:0] a);
    return bus_mem.exists(a) ? bus_mem[a] : fill_word(a);
  endfunction

  task automatic next_rand(input int n, output int v);
    main_seed = lcg_step(main_seed);
    v = int'(main_seed[31:16]) % n;
  endtask

  initial
  begin
    CPU_CLK = 1'b0;
    forever #50 CPU_CLK = ~CPU_CLK;
  end

  // ----------------------------------------
  // memory responder and bus grant
  // ----------------------------------------
  always @(posedge CPU_CLK)
  begin
    if (RST)
    begin
      bus_seed = lcg_step(bus_seed);
      dma_mcu_access <= stress ? bus_seed[20] : (bus_seed[20:17] != 4'h0);
      assert ((!mem_do_act || dma_mcu_access) && (!mem_we || mem_do_act) &&
              (!mmu_fault || cache_done) && (!cache_done || cache_busy))
      else
      begin
        bus_errors++;
        $display("bus or completion rule broken at %0t", $time);
      end
      if (mem_do_act && mem_ack)
      begin
        assert (exp_ops.size() > 0)
        else
        begin
          bus_errors++;
          $display("bus operation at %h that no access asked for", mem_addr);
        end
        if (exp_ops.size() > 0)
        begin
          bus_op = exp_ops.pop_front();
          assert (mem_we === bus_op.wr && mem_addr === bus_op.addr &&
                  (!bus_op.wr || mem_dataintomem === bus_op.data))
          else
          begin
            bus_errors++;
            $display("ERROR %s: bus op expected %b %h %h actual %b %h %h", test_name,
                     bus_op.wr, bus_op.addr, bus_op.data, mem_we, mem_addr, mem_dataintomem);
          end
        end
        if (mem_we)
        begin
          bus_mem[mem_addr] = mem_dataintomem;
        end
        mem_ack <= 1'b0;
      end
      else if (mem_do_act && !mem_ack)
      begin
        if (ack_delay == 0)
        begin
          mem_ack         <= 1'b1;
          mem_datafrommem <= bus_word(mem_addr);
          ack_delay       = int'(bus_seed[27:24]) & (stress ? 15 : 1);
        end
        else
        begin
          ack_delay--;
        end
      end
    end
  end

  // ----------------------------------------
  // one CPU access, predicted then checked
  // ----------------------------------------
  task automatic do_access(input bit tlb, input bit we, input bit inh, input bit vm,
                           input logic [31:0] a, input logic [31:0] d, output int lat);
    logic [ADDR_W-1:0]  pa;
    logic [INDEX_W-1:0] ti;
    logic [INDEX_W-1:0] ci;
    logic [DATA_W-1:0]  exp_rd;
    bit                 fault;
    bit                 hit;
    int                 k;
    lat    = 0;
    k      = 0;
    ti     = a[17:10];
    fault  = !tlb && vm && !(t_valid[ti] && t_vtag[ti] == a[31:18]);
    pa     = (vm && !tlb) ? {t_ptag[ti], a[17:0]} : a;
    ci     = pa[9:2];
    hit    = !tlb && !fault && !we && !inh && c_valid[ci] && c_tag[ci] == pa[31:10];
    exp_rd = ref_word(pa);
    while (cache_busy !== 1'b0 && k < 50)
    begin
      @(posedge CPU_CLK);
      k++;
    end
    assert (k < 50)
    else
    begin
      hang_errors++;
      hung = 1'b1;
      $display("cache_busy never dropped before a new access");
    end
    if (hung)
    begin
      return;
    end
    cache_enable  <= !tlb;
    tlb_we        <= tlb;
    cache_we      <= we;
    cache_inhibit <= inh;
    vmem_act      <= vm;
    cache_addr    <= a;
    cache_wdata   <= d;
    @(posedge CPU_CLK);                      // accepted on this edge
    cache_enable <= 1'b0;
    tlb_we       <= 1'b0;
    if (tlb)
    begin
      t_valid[ti] = 1'b1;
      t_ptag[ti]  = d[29:16];
      t_vtag[ti]  = d[13:0];
    end
    else if (!fault && (we || !hit))
    begin
      exp_ops.push_back('{we, pa, d});
      if (we)
      begin
        ref_mem[pa] = d;
      end
      if (we || !inh)
      begin
        c_valid[ci] = !inh;                  // inhibited write drops the line
        c_tag[ci]   = pa[31:10];
      end
    end
    while (cache_done !== 1'b1 && lat < 3000)
    begin
      @(posedge CPU_CLK);
      lat++;
      assert (cache_busy === 1'b1)
      else
      begin
        timing_errors++;
        $display("cache_busy low while access at %h pending", a);
      end
      assert (!hit || !(mem_do_act === 1'b1 && mem_we !== 1'b1))
      else
      begin
        bus_errors++;
        $display("cache hit at %h still read memory", pa);
      end
    end
    assert (lat < 3000)
    else
    begin
      hang_errors++;
      hung = 1'b1;
      $display("no cache_done for access at %h", a);
    end
    if (hung)
    begin
      return;
    end
    assert (mmu_fault === fault)
    else
    begin
      data_errors++;
      $display("ERROR %s: fault at %h expected %b actual %b", test_name, a, fault, mmu_fault);
    end
    assert (tlb || we || fault || cache_rdata === exp_rd)
    else
    begin
      data_errors++;
      $display("ERROR %s: read %h expected %h actual %h", test_name, pa, exp_rd, cache_rdata);
    end
    assert (!(tlb || fault || hit) || lat == 2)
    else
    begin
      timing_errors++;
      $display("ERROR %s: latency at %h expected 2 actual %0d", test_name, a, lat);
    end
  endtask

  task automatic random_access();
    int r;
    int w;
    int n;
    int v;
    int vt;
    int pg;
    int ix;
    int pt;
    int hi;
    int lo;
    int lat;
    logic [ADDR_W-1:0] a;
    next_rand(100, r);
    next_rand(100, w);
    next_rand(100, n);
    next_rand(2, v);
    next_rand(2, vt);
    next_rand(2, pg);
    next_rand(8, ix);
    next_rand(2, pt);
    next_rand(65536, hi);
    next_rand(65536, lo);
    a = ADDR_W'((vt << 18) | (pg << 10) | (ix << 2));   // few pages, few lines
    if (r < 8)
    begin
      do_access(1'b1, 1'b0, 1'b0, 1'b0, a, DATA_W'((pt << 16) | vt), lat);
    end
    else
    begin
      do_access(1'b0, w < 40, n < 15, v == 1, a, DATA_W'((hi << 16) | lo), lat);
    end
  endtask

  // ----------------------------------------
  // sequence of tests
  // ----------------------------------------
  initial
  begin
    int i;
    int lat;
    int max_lat;
    int hi;
    int lo;
    main_seed       = 32'd68215;
    bus_seed        = lcg_step(32'd68215);
    RST             = 1'b0;
    cache_addr      = '0;
    cache_wdata     = '0;
    cache_we        = 1'b0;
    cache_enable    = 1'b0;
    tlb_we          = 1'b0;
    cache_inhibit   = 1'b0;
    vmem_act        = 1'b0;
    dma_mcu_access  = 1'b0;
    mem_ack         = 1'b0;
    mem_datafrommem = '0;
    ack_delay       = 0;
    stress          = 1'b0;
    hung            = 1'b0;
    data_errors     = 0;
    bus_errors      = 0;
    timing_errors   = 0;
    hang_errors     = 0;
    test_name       = "reset";
    repeat (10) @(posedge CPU_CLK);
    RST <= 1'b1;
    assert (cache_busy === 1'b0 && cache_done === 1'b0 && mmu_fault === 1'b0 &&
            mem_do_act === 1'b0 && mem_we === 1'b0)
    else
    begin
      timing_errors++;
      $display("outputs not cleared by reset");
    end
    test_name = "random";
    for (i = 0; i < 300 && !hung; i++)
    begin
      random_access();
    end
    test_name = "stress";
    stress <= 1'b1;                          // slow acks, grant half the time
    for (i = 0; i < 200 && !hung; i++)
    begin
      random_access();
    end
    test_name = "burst";
    max_lat   = 0;
    for (i = 0; i < 10 && !hung; i++)
    begin
      next_rand(65536, hi);
      next_rand(65536, lo);
      do_access(1'b0, 1'b1, 1'b0, 1'b0, i << 2, DATA_W'((hi << 16) | lo), lat);
      max_lat = (lat > max_lat) ? lat : max_lat;
    end
    assert (hung || max_lat > 2)
    else
    begin
      timing_errors++;
      $display("ERROR %s: write latency expected above 2 actual %0d", test_name, max_lat);
    end
    for (i = 0; i < 10 && !hung; i++)
    begin
      do_access(1'b0, 1'b0, 1'b0, 1'b0, i << 2, '0, lat);
    end
    stress <= 1'b0;
    i = 0;
    while (exp_ops.size() != 0 && i < 5000 && !hung)
    begin
      @(posedge CPU_CLK);
      i++;
    end
    assert (hung || exp_ops.size() == 0)
    else
    begin
      hang_errors++;
      $display("%0d posted operations never reached memory", exp_ops.size());
    end
    $display("errors: data %0d, bus %0d, timing %0d, timeout %0d",
             data_errors, bus_errors, timing_errors, hang_errors);
    if (data_errors + bus_errors + timing_errors + hang_errors == 0)
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- bench/cache_assertions.sv
`timescale 1ns/1ps

module cache_assertions (
  input logic CPU_CLK,
  input logic RST,
  input logic dma_mcu_access,
  input logic mem_do_act,
  input logic mem_we,
  input logic mmu_fault,
  input logic cache_done,
  input logic cache_busy
);

  // ----------------------------------------
  // memory bus
  // ----------------------------------------
  request_needs_grant: assert property (@(posedge CPU_CLK) disable iff (!RST)
    mem_do_act |-> dma_mcu_access)
    else $error("memory request without grant");

  write_needs_request: assert property (@(posedge CPU_CLK) disable iff (!RST)
    mem_we |-> mem_do_act)
    else $error("mem_we without mem_do_act");

  // ----------------------------------------
  // CPU completion
  // ----------------------------------------
  fault_with_done: assert property (@(posedge CPU_CLK) disable iff (!RST)
    mmu_fault |-> cache_done)
    else $error("mmu_fault outside cache_done");

  done_while_busy: assert property (@(posedge CPU_CLK) disable iff (!RST)
    cache_done |-> cache_busy)
    else $error("cache_done with cache_busy low");

endmodule

bind snowball_cache_top cache_assertions cache_assertions_i (
  .CPU_CLK        (CPU_CLK),
  .RST            (RST),
  .dma_mcu_access (dma_mcu_access),
  .mem_do_act     (mem_do_act),
  .mem_we         (mem_we),
  .mmu_fault      (mmu_fault),
  .cache_done     (cache_done),
  .cache_busy     (cache_busy)
);

//--- verilog/snowball_cache_top.sv
`timescale 1ns/1ps

module snowball_cache_top (
  input  logic                         CPU_CLK,
  input  logic                         RST,
  input  logic [cache_pkg::ADDR_W-1:0] cache_addr,
  input  logic [cache_pkg::DATA_W-1:0] cache_wdata,
  input  logic                         cache_we,
  input  logic                         cache_enable,
  input  logic                         tlb_we,
  input  logic                         cache_inhibit,
  input  logic                         vmem_act,
  output logic [cache_pkg::DATA_W-1:0] cache_rdata,
  output logic                         cache_busy,
  output logic                         cache_done,
  output logic                         mmu_fault,
  input  logic                         dma_mcu_access,
  output logic [cache_pkg::ADDR_W-1:0] mem_addr,
  output logic                         mem_we,
  output logic                         mem_do_act,
  output logic [cache_pkg::DATA_W-1:0] mem_dataintomem,
  input  logic                         mem_ack,
  input  logic [cache_pkg::DATA_W-1:0] mem_datafrommem
);

  import cache_pkg::*;

  logic               enq_valid;
  mem_op_t            enq_op;
  logic               full;
  logic               deq_pop;
  mem_op_t            deq_op;
  logic               empty;
  logic               fill_valid;
  logic [DATA_W-1:0]  fill_data;

  logic [INDEX_W-1:0] ram_raddr;
  logic [DATA_W-1:0]  data_rdata;
  logic [CTAG_W-1:0]  tag_rdata;
  logic [INDEX_W-1:0] tlb_raddr;
  logic [TLB_W-1:0]   tlb_rdata;
  logic               data_we;
  logic [INDEX_W-1:0] data_waddr;
  logic [DATA_W-1:0]  data_wdata;
  logic [CTAG_W-1:0]  tag_wdata;
  logic               tlb_ram_we;
  logic [INDEX_W-1:0] tlb_waddr;
  logic [TLB_W-1:0]   tlb_wdata;

  cache_lookup cache_lookup_i (.*);

  mem_request_fifo mem_request_fifo_i (.*);

  mem_sequencer mem_sequencer_i (.*);

  // ----------------------------------------
  // arrays
  // ----------------------------------------
  cache_ram #(.WIDTH(DATA_W), .DEPTH(ENTRIES)) data_ram (
    .CPU_CLK (CPU_CLK),
    .raddr   (ram_raddr),
    .rdata   (data_rdata),
    .waddr   (data_waddr),
    .wdata   (data_wdata),
    .we      (data_we)
  );

  cache_ram #(.WIDTH(CTAG_W), .DEPTH(ENTRIES)) tag_ram (
    .CPU_CLK (CPU_CLK),
    .raddr   (ram_raddr),                    // same index as data
    .rdata   (tag_rdata),
    .waddr   (data_waddr),
    .wdata   (tag_wdata),
    .we      (data_we)
  );

  cache_ram #(.WIDTH(TLB_W), .DEPTH(ENTRIES)) tlb_ram (
    .CPU_CLK (CPU_CLK),
    .raddr   (tlb_raddr),
    .rdata   (tlb_rdata),
    .waddr   (tlb_waddr),
    .wdata   (tlb_wdata),
    .we      (tlb_ram_we)
  );

endmodule

//--- cache/mem_sequencer.sv
`timescale 1ns/1ps

module mem_sequencer (
  input  logic                         CPU_CLK,
  input  logic                         RST,
  input  cache_pkg::mem_op_t           deq_op,
  input  logic                         empty,
  output logic                         deq_pop,
  input  logic                         dma_mcu_access,
  output logic [cache_pkg::ADDR_W-1:0] mem_addr,
  output logic                         mem_we,
  output logic                         mem_do_act,
  output logic [cache_pkg::DATA_W-1:0] mem_dataintomem,
  input  logic                         mem_ack,
  input  logic [cache_pkg::DATA_W-1:0] mem_datafrommem,
  output logic                         fill_valid,
  output logic [cache_pkg::DATA_W-1:0] fill_data
);

  logic req_q;                               // request held on the bus
  logic wr_q;
  logic load;
  logic done_beat;

  // ----------------------------------------
  // bus side
  // ----------------------------------------
  assign mem_do_act = req_q && dma_mcu_access;   // grant drops it at once
  assign mem_we     = wr_q && mem_do_act;
  assign done_beat  = mem_do_act && mem_ack;
  assign load       = !req_q && !empty;

  assign deq_pop = done_beat;                // head leaves with the ack

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      req_q      <= 1'b0;
      wr_q       <= 1'b0;
      fill_valid <= 1'b0;
    end
    else
    begin
      fill_valid <= done_beat && !wr_q;      // one cycle after the ack
      if (done_beat)
      begin
        req_q <= 1'b0;
      end
      else if (load)
      begin
        req_q <= 1'b1;
        wr_q  <= deq_op.wr;
      end
    end
  end

  // ----------------------------------------
  // address, write data and read return
  // ----------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (load)
    begin
      mem_addr        <= deq_op.addr;        // held until the ack
      mem_dataintomem <= deq_op.data;
    end
    if (done_beat && !wr_q)
    begin
      fill_data <= mem_datafrommem;
    end
  end

endmodule

//--- cache/mem_request_fifo.sv
`timescale 1ns/1ps

module mem_request_fifo (
  input  logic               CPU_CLK,
  input  logic               RST,
  input  logic               enq_valid,
  input  cache_pkg::mem_op_t enq_op,
  output logic               full,
  input  logic               deq_pop,
  output cache_pkg::mem_op_t deq_op,
  output logic               empty
);

  import cache_pkg::*;

  mem_op_t          slots [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign full  = (count == CNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);
  assign push  = enq_valid && !full;
  assign pop   = deq_pop && !empty;

  assign deq_op = slots[rd_ptr];             // head, valid while not empty

  always_ff @(posedge CPU_CLK)
  begin
    if (push)
    begin
      slots[wr_ptr] <= enq_op;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;             // wraps at depth
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop)
      begin
        count <= count + 1'b1;
      end
      else if (pop && !push)
      begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- cache/cache_lookup.sv
`timescale 1ns/1ps

module cache_lookup (
  input  logic                          CPU_CLK,
  input  logic                          RST,
  input  logic [cache_pkg::ADDR_W-1:0]  cache_addr,
  input  logic [cache_pkg::DATA_W-1:0]  cache_wdata,
  input  logic                          cache_we,
  input  logic                          cache_enable,
  input  logic                          tlb_we,
  input  logic                          cache_inhibit,
  input  logic                          vmem_act,
  output logic [cache_pkg::DATA_W-1:0]  cache_rdata,
  output logic                          cache_busy,
  output logic                          cache_done,
  output logic                          mmu_fault,
  output logic                          enq_valid,
  output cache_pkg::mem_op_t            enq_op,
  input  logic                          full,
  input  logic                          fill_valid,
  input  logic [cache_pkg::DATA_W-1:0]  fill_data,
  output logic [cache_pkg::INDEX_W-1:0] ram_raddr,
  input  logic [cache_pkg::DATA_W-1:0]  data_rdata,
  input  logic [cache_pkg::CTAG_W-1:0]  tag_rdata,
  output logic [cache_pkg::INDEX_W-1:0] tlb_raddr,
  input  logic [cache_pkg::TLB_W-1:0]   tlb_rdata,
  output logic                          data_we,
  output logic [cache_pkg::INDEX_W-1:0] data_waddr,
  output logic [cache_pkg::DATA_W-1:0]  data_wdata,
  output logic [cache_pkg::CTAG_W-1:0]  tag_wdata,
  output logic                          tlb_ram_we,
  output logic [cache_pkg::INDEX_W-1:0] tlb_waddr,
  output logic [cache_pkg::TLB_W-1:0]   tlb_wdata
);

  import cache_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_lookup,
    st_wait_q,
    st_wait_fill
  } state_t;

  state_t state;

  logic [ADDR_W-1:0]  addr_q;
  logic [DATA_W-1:0]  wdata_q;
  logic               we_q;
  logic               inh_q;
  logic               vm_q;
  logic               is_tlb_q;
  logic [ADDR_W-1:0]  pa_q;
  logic [ENTRIES-1:0] cache_vld;
  logic [ENTRIES-1:0] tlb_vld;

  logic               accept;
  logic [INDEX_W-1:0] cidx;
  logic [INDEX_W-1:0] tidx;
  logic [VTAG_W-1:0]  ptag;
  logic [VTAG_W-1:0]  vtag;
  logic [ADDR_W-1:0]  pa_c;
  logic [ADDR_W-1:0]  pa;
  logic               fault;
  logic               hit;

  // ----------------------------------------
  // request capture and array read
  // ----------------------------------------
  assign accept    = (cache_enable || tlb_we) && !cache_busy;
  assign ram_raddr = cache_addr[9:2];        // arrays read on the accept edge
  assign tlb_raddr = cache_addr[17:10];

  always_ff @(posedge CPU_CLK)
  begin
    if (state == st_idle && accept)
    begin
      addr_q   <= cache_addr;
      wdata_q  <= cache_wdata;
      we_q     <= cache_we;
      is_tlb_q <= !cache_enable;             // cache access wins
      inh_q    <= cache_inhibit;
      vm_q     <= vmem_act;
    end
    if (state == st_lookup)
    begin
      pa_q <= pa_c;
    end
    if (state == st_lookup && !is_tlb_q && !fault && !we_q && hit)
    begin
      cache_rdata <= data_rdata;
    end
    else if (state == st_wait_fill && fill_valid)
    begin
      cache_rdata <= fill_data;
    end
  end

  // ----------------------------------------
  // translation and tag compare
  // ----------------------------------------
  assign cidx         = addr_q[9:2];
  assign tidx         = addr_q[17:10];
  assign {ptag, vtag} = tlb_rdata;

  assign fault = vm_q && !(tlb_vld[tidx] && vtag == addr_q[31:18]);
  assign pa_c  = vm_q ? {ptag, addr_q[17:0]} : addr_q;
  assign pa    = (state == st_lookup) ? pa_c : pa_q;
  assign hit   = !inh_q && cache_vld[cidx] && tag_rdata == pa_c[31:10];

  // ----------------------------------------
  // queue and array writes
  // ----------------------------------------
  always_comb
  begin
    enq_valid = 1'b0;
    if (!full)
    begin
      if (state == st_wait_q)
      begin
        enq_valid = 1'b1;
      end
      else if (state == st_lookup && !is_tlb_q && !fault && (we_q || !hit))
      begin
        enq_valid = 1'b1;
      end
    end
  end

  assign enq_op = '{wr: we_q, addr: pa, data: wdata_q};

  assign data_we = (enq_valid && we_q && !inh_q) ||
                   (state == st_wait_fill && fill_valid && !inh_q);
  assign data_waddr = cidx;
  assign data_wdata = (state == st_wait_fill) ? fill_data : wdata_q;
  assign tag_wdata  = pa[31:10];

  assign tlb_ram_we = (state == st_lookup) && is_tlb_q;
  assign tlb_waddr  = tidx;
  assign tlb_wdata  = {wdata_q[29:16], wdata_q[13:0]};

  // ----------------------------------------
  // control FSM
  // ----------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state      <= st_idle;
      cache_busy <= 1'b0;
      cache_done <= 1'b0;
      mmu_fault  <= 1'b0;
      cache_vld  <= '0;
      tlb_vld    <= '0;
    end
    else
    begin
      cache_done <= 1'b0;
      mmu_fault  <= 1'b0;
      if (cache_done)
      begin
        cache_busy <= 1'b0;                  // drops the cycle after done
      end

      case (state)
        st_idle:
          if (accept)
          begin
            state      <= st_lookup;
            cache_busy <= 1'b1;
          end
        st_lookup:
          if (is_tlb_q)
          begin
            tlb_vld[tidx] <= 1'b1;
            cache_done    <= 1'b1;
            state         <= st_idle;
          end
          else if (fault)
          begin
            mmu_fault  <= 1'b1;              // no state change, no bus op
            cache_done <= 1'b1;
            state      <= st_idle;
          end
          else if (!we_q && hit)
          begin
            cache_done <= 1'b1;
            state      <= st_idle;
          end
          else if (full)
          begin
            state <= st_wait_q;
          end
          else if (we_q)
          begin
            cache_done <= 1'b1;              // posted
            state      <= st_idle;
          end
          else
          begin
            state <= st_wait_fill;
          end
        st_wait_q:
          if (!full)
          begin
            if (we_q)
            begin
              cache_done <= 1'b1;
              state      <= st_idle;
            end
            else
            begin
              state <= st_wait_fill;
            end
          end
        st_wait_fill:
          if (fill_valid)
          begin
            cache_done <= 1'b1;
            state      <= st_idle;
            if (!inh_q)
            begin
              cache_vld[cidx] <= 1'b1;
            end
          end
        default:
          state <= st_idle;
      endcase

      if (enq_valid && we_q)
      begin
        cache_vld[cidx] <= !inh_q;           // inhibited write drops the line
      end
    end
  end

endmodule

//--- verilog/cache_ram.sv
`timescale 1ns/1ps

module cache_ram #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 256
) (
  input  logic                     CPU_CLK,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output logic [WIDTH-1:0]         rdata,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  logic [WIDTH-1:0]         wdata,
  input  logic                     we
);

  logic [WIDTH-1:0] mem [DEPTH];

  // read returns old contents on a same-address write
  always_ff @(posedge CPU_CLK)
  begin
    if (we)
    begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];                     // registered read port
  end

endmodule

//--- common/cache_pkg.sv
package cache_pkg;

  // ----------------------------------------
  // bus and array geometry
  // ----------------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  localparam int INDEX_W = 8;                // cache idx 9:2, table idx 17:10
  localparam int ENTRIES = 1 << INDEX_W;

  localparam int CTAG_W = 22;                // physical bits 31:10
  localparam int VTAG_W = 14;                // page tag, bits 31:18
  localparam int TLB_W = 2 * VTAG_W;         // {ptag, vtag}

  // ----------------------------------------
  // request queue
  // ----------------------------------------
  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // one pending memory operation, 65 bits
  typedef struct packed {
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_op_t;

endpackage
